//--- uart_macros.svh
/* uart macros: character, divider and bus widths plus the register map. */
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// character and bit-period widths.
`define UART_DATA_W 8
`define UART_DIV_W  16

// divider loaded by reset, a fast default for simulation.
`define UART_DIV_RST 16

// wishbone address width, registers on word addresses 0 to 3.
`define UART_ADR_W 4

`define UART_REG_CTRL   4'd0
`define UART_REG_STATUS 4'd1
`define UART_REG_TXDATA 4'd2
`define UART_REG_RXDATA 4'd3

`endif

//--- uart_pkg.sv
/* uart package: serial states, register map and the structs passed
   between decoder, transmitter and receiver. */
`include "uart_macros.svh"

package uart_pkg;

    // shared by both engines, the receiver never enters WAIT.
    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        PARITY,
        STOP,
        WAIT
    } uart_state_e;

    typedef enum logic [`UART_ADR_W-1:0] {
        REG_CTRL   = `UART_REG_CTRL,
        REG_STATUS = `UART_REG_STATUS,
        REG_TXDATA = `UART_REG_TXDATA,
        REG_RXDATA = `UART_REG_RXDATA
    } uart_reg_e;

    // field order matches the CTRL register layout, bit 17 down to 0.
    typedef struct packed {
        logic                   par_even;
        logic                   par_odd;   // wins over par_even.
        logic [`UART_DIV_W-1:0] div;       // clocks per bit.
    } uart_cfg_t;

    typedef struct packed {
        logic                    valid;
        logic [`UART_DATA_W-1:0] data;
    } uart_stream_t;

    typedef struct packed {
        logic                    valid;
        logic [`UART_DATA_W-1:0] data;
        logic                    par_err;
        logic                    frame_err;
        logic                    overrun;
    } uart_rx_stat_t;

endpackage

//--- uart_wb_decode.sv
/* uart register decoder: wishbone classic slave holding the control
   register and steering TXDATA, STATUS and RXDATA to the engines. */
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_wb_decode (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic [`UART_ADR_W-1:0]   wb_adr_i,
    input  logic [31:0]              wb_dat_i,
    input  logic                     wb_we_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_cyc_i,
    output logic [31:0]              wb_dat_o,
    output logic                     wb_ack_o,
    output uart_pkg::uart_cfg_t      cfg_o,
    output uart_pkg::uart_stream_t   tx_stream_o,
    input  logic                     tx_ready_i,
    input  uart_pkg::uart_rx_stat_t  rx_stat_i,
    output logic                     rx_clear_o
);

    import uart_pkg::*;

    localparam int CFG_W = $bits(uart_cfg_t);

    uart_reg_e   reg_sel;
    logic        req;
    logic        tx_wr;
    logic        ack_d;
    logic [31:0] rd_data;

    assign reg_sel = uart_reg_e'(wb_adr_i);
    assign req     = wb_cyc_i & wb_stb_i & ~wb_ack_o; // no second ack for the same access.
    assign tx_wr   = req & wb_we_i & (reg_sel == REG_TXDATA);

    // a TXDATA write waits here until the transmitter takes the byte.
    assign ack_d = req & (~tx_wr | tx_ready_i);

    // valid follows the held bus request until the byte is accepted.
    assign tx_stream_o.valid = tx_wr;
    assign tx_stream_o.data  = wb_dat_i[`UART_DATA_W-1:0];

    always_comb begin
        rd_data = '0;
        case (reg_sel)
            REG_CTRL:   rd_data[CFG_W-1:0] = cfg_o;
            REG_STATUS: begin
                rd_data[0] = tx_ready_i;
                rd_data[1] = rx_stat_i.valid;
                rd_data[2] = rx_stat_i.par_err;
                rd_data[3] = rx_stat_i.frame_err;
                rd_data[4] = rx_stat_i.overrun;
            end
            REG_RXDATA: rd_data[`UART_DATA_W-1:0] = rx_stat_i.data;
            default:    rd_data = '0; // TXDATA and unmapped words read zero.
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            wb_ack_o   <= 1'b0;
            rx_clear_o <= 1'b0;
            cfg_o      <= '{par_even: 1'b0, par_odd: 1'b0, div: `UART_DIV_W'(`UART_DIV_RST)};
        end else begin
            wb_ack_o   <= ack_d;
            rx_clear_o <= req & ~wb_we_i & (reg_sel == REG_RXDATA); // lands in the ack cycle.
            if (req & wb_we_i & (reg_sel == REG_CTRL)) begin
                cfg_o <= uart_cfg_t'(wb_dat_i[CFG_W-1:0]);
            end
        end
    end

    // read data is captured with the request and shown during ack.
    always_ff @(posedge clk_i) begin
        if (req & ~wb_we_i) begin
            wb_dat_o <= rd_data;
        end
    end

endmodule

//--- uart_tx.sv
/* uart transmitter: start bit, 8 data bits lsb first, optional parity
   and one stop bit, each bit lasting cfg_i.div clocks. */
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_tx (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  uart_pkg::uart_cfg_t    cfg_i,
    input  uart_pkg::uart_stream_t s_stream_i,
    output logic                   s_ready_o,
    output logic                   uart_tx_o
);

    import uart_pkg::*;

    localparam int BIT_CNT_W = $clog2(`UART_DATA_W);

    uart_state_e             state;
    logic [`UART_DIV_W-1:0]  baud_cnt;
    logic [BIT_CNT_W-1:0]    bit_cnt;
    logic [`UART_DATA_W-1:0] shreg;
    logic                    par_bit;
    logic                    par_en;
    logic                    baud_done;
    logic                    bit_done;
    logic                    accept;

    assign par_en    = cfg_i.par_odd | cfg_i.par_even;
    assign baud_done = (baud_cnt == cfg_i.div - 1'b1);
    assign bit_done  = (bit_cnt == BIT_CNT_W'(`UART_DATA_W - 1));
    assign s_ready_o = (state == IDLE);
    assign accept    = s_stream_i.valid & s_ready_o;

    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            state     <= IDLE;
            uart_tx_o <= 1'b1;
            bit_cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state     <= START;
                        uart_tx_o <= 1'b0; // line falls the clock after accept.
                    end
                end
                START: begin
                    if (baud_done) begin
                        state     <= DATA;
                        uart_tx_o <= shreg[0];
                    end
                end
                DATA: begin
                    if (baud_done) begin
                        if (bit_done) begin
                            bit_cnt <= '0;
                            if (par_en) begin
                                state     <= PARITY;
                                uart_tx_o <= par_bit;
                            end else begin
                                state     <= STOP;
                                uart_tx_o <= 1'b1;
                            end
                        end else begin
                            bit_cnt   <= bit_cnt + 1'b1;
                            uart_tx_o <= shreg[1]; // next bit before the shift lands.
                        end
                    end
                end
                PARITY: begin
                    if (baud_done) begin
                        state     <= STOP;
                        uart_tx_o <= 1'b1;
                    end
                end
                STOP: begin
                    if (baud_done) begin
                        state <= WAIT;
                    end
                end
                WAIT: state <= IDLE;
                default: begin
                    state     <= IDLE;
                    uart_tx_o <= 1'b1;
                end
            endcase
        end
    end

    // bit period counter, restarted at every bit boundary.
    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            baud_cnt <= '0;
        end else if (state == IDLE || state == WAIT || baud_done) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // odd parity inverts the xor of the data bits.
    always_ff @(posedge clk_i) begin
        if (accept) begin
            shreg   <= s_stream_i.data;
            par_bit <= ^s_stream_i.data ^ cfg_i.par_odd;
        end else if (state == DATA && baud_done) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

//--- uart_rx.sv
/* uart receiver: mid-bit sampling of the synchronized line with parity
   and stop bit checks, holding the byte until the bus clears it. */
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_rx (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  uart_pkg::uart_cfg_t     cfg_i,
    input  logic                    uart_rx_i,
    input  logic                    clear_i,
    output uart_pkg::uart_rx_stat_t stat_o
);

    import uart_pkg::*;

    localparam int BIT_CNT_W = $clog2(`UART_DATA_W);

    uart_state_e             state;
    logic [1:0]              rx_sync;
    logic                    rx_prev;
    logic                    line;
    logic                    fall;
    logic [`UART_DIV_W-1:0]  baud_cnt;
    logic [BIT_CNT_W-1:0]    bit_cnt;
    logic [`UART_DATA_W-1:0] shreg;
    logic                    half_done;
    logic                    baud_done;
    logic                    bit_done;
    logic                    par_en;
    logic                    par_bad;
    logic                    stop_done;
    logic                    rx_valid;
    logic                    rx_par_err;
    logic                    rx_frame_err;
    logic                    rx_overrun;
    logic [`UART_DATA_W-1:0] rx_data;

    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            rx_sync <= '1;
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], uart_rx_i};
            rx_prev <= rx_sync[1];
        end
    end

    assign line      = rx_sync[1];
    assign fall      = rx_prev & ~line;
    assign par_en    = cfg_i.par_odd | cfg_i.par_even;
    assign half_done = (baud_cnt == (cfg_i.div >> 1) - 1'b1); // divider of 2 or more.
    assign baud_done = (baud_cnt == cfg_i.div - 1'b1);
    assign bit_done  = (bit_cnt == BIT_CNT_W'(`UART_DATA_W - 1));
    assign stop_done = (state == STOP) && baud_done;

    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            state   <= IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                IDLE:   if (fall) state <= START;
                START: begin
                    if (half_done) begin
                        state <= line ? IDLE : DATA; // high at midpoint is a glitch.
                    end
                end
                DATA: begin
                    if (baud_done) begin
                        if (bit_done) begin
                            bit_cnt <= '0;
                            state   <= par_en ? PARITY : STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                PARITY: if (baud_done) state <= STOP;
                STOP:   if (baud_done) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // counts half a period in START, then whole periods from mid-bit to mid-bit.
    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            baud_cnt <= '0;
        end else if (state == IDLE || (state == START && half_done) || baud_done) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == START) begin
            par_bad <= 1'b0;
        end else if (state == DATA && baud_done) begin
            shreg <= {line, shreg[`UART_DATA_W-1:1]};
        end else if (state == PARITY && baud_done) begin
            par_bad <= (line != (^shreg ^ cfg_i.par_odd));
        end
    end

    // a new byte wins over a clear arriving in the same cycle.
    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            rx_valid     <= 1'b0;
            rx_par_err   <= 1'b0;
            rx_frame_err <= 1'b0;
            rx_overrun   <= 1'b0;
        end else if (stop_done) begin
            rx_valid     <= 1'b1;
            rx_par_err   <= par_bad;
            rx_frame_err <= ~line;
            rx_overrun   <= (rx_overrun | rx_valid) & ~clear_i;
        end else if (clear_i) begin
            rx_valid     <= 1'b0;
            rx_par_err   <= 1'b0;
            rx_frame_err <= 1'b0;
            rx_overrun   <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stop_done) begin
            rx_data <= shreg; // overwrites an unread byte.
        end
    end

    assign stat_o.valid     = rx_valid;
    assign stat_o.data      = rx_data;
    assign stat_o.par_err   = rx_par_err;
    assign stat_o.frame_err = rx_frame_err;
    assign stat_o.overrun   = rx_overrun;

endmodule

//--- uart_top.sv
/* uart top level: wishbone register decoder driving a transmitter and
   a receiver. */
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_top (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic [`UART_ADR_W-1:0] wb_adr_i,
    input  logic [31:0]            wb_dat_i,
    input  logic                   wb_we_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_cyc_i,
    output logic [31:0]            wb_dat_o,
    output logic                   wb_ack_o,
    output logic                   uart_tx_o,
    input  logic                   uart_rx_i
);

    import uart_pkg::*;

    uart_cfg_t     cfg;
    uart_stream_t  tx_stream;
    logic          tx_ready;
    uart_rx_stat_t rx_stat;
    logic          rx_clear;

    uart_wb_decode u_decode (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_we_i     (wb_we_i),
        .wb_stb_i    (wb_stb_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .cfg_o       (cfg),
        .tx_stream_o (tx_stream),
        .tx_ready_i  (tx_ready),
        .rx_stat_i   (rx_stat),
        .rx_clear_o  (rx_clear)
    );

    uart_tx u_tx (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .cfg_i      (cfg),
        .s_stream_i (tx_stream),
        .s_ready_o  (tx_ready),
        .uart_tx_o  (uart_tx_o)
    );

    uart_rx u_rx (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .cfg_i     (cfg),
        .uart_rx_i (uart_rx_i),
        .clear_i   (rx_clear),
        .stat_o    (rx_stat)
    );

endmodule

//--- uart_sva.sv
/* uart assertions: wishbone ack rules, idle line level and start bit width. */
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_sva (
    input logic                   clk_i,
    input logic                   rstn_i,
    input logic                   wb_stb_i,
    input logic                   wb_cyc_i,
    input logic                   wb_ack_i,
    input logic                   tx_ready_i,
    input uart_pkg::uart_stream_t tx_stream_i,
    input logic                   uart_tx_i,
    input uart_pkg::uart_cfg_t    cfg_i
);

    import uart_pkg::*;

    int unsigned            fail_cnt = 0;
    logic                   prev_tx;
    logic                   prev_ready;
    logic                   first_bit;
    logic                   start_fall;
    logic [`UART_DIV_W-1:0] start_cnt;    // low cycles seen in the current start bit.

    // a start bit begins where the line and ready fall together.
    assign start_fall = prev_tx & ~uart_tx_i & prev_ready & ~tx_ready_i;

    always_ff @(posedge clk_i) begin
        if (~rstn_i) begin
            prev_tx    <= 1'b1;
            prev_ready <= 1'b1;
            start_cnt  <= '0;
        end else begin
            prev_tx    <= uart_tx_i;
            prev_ready <= tx_ready_i;
            if (tx_stream_i.valid && tx_ready_i) begin
                first_bit <= tx_stream_i.data[0];
            end
            if (start_fall) begin
                start_cnt <= `UART_DIV_W'(1);
            end else if (start_cnt == cfg_i.div) begin
                start_cnt <= '0;
            end else if (start_cnt != '0) begin
                start_cnt <= start_cnt + 1'b1;
            end
        end
    end

    ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_ack_i |-> (wb_stb_i && wb_cyc_i))
        else begin
            $error("ack seen without stb and cyc");
            fail_cnt++;
        end

    ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_ack_i |=> !wb_ack_i)
        else begin
            $error("ack held for more than one cycle");
            fail_cnt++;
        end

    idle_high: assert property (@(posedge clk_i) disable iff (!rstn_i)
        tx_ready_i |-> uart_tx_i)
        else begin
            $error("tx line low while transmitter ready");
            fail_cnt++;
        end

    start_low: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (start_cnt != '0 && start_cnt < cfg_i.div) |-> !uart_tx_i)
        else begin
            $error("start bit ended before divider cycles");
            fail_cnt++;
        end

    // after exactly div low cycles the line carries data bit 0.
    start_end: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (start_cnt == cfg_i.div) |-> (uart_tx_i == first_bit))
        else begin
            $error("start bit not followed by data bit 0 after divider cycles");
            fail_cnt++;
        end

endmodule

bind uart_top uart_sva u_sva (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .wb_stb_i    (wb_stb_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_ack_i    (wb_ack_o),
    .tx_ready_i  (tx_ready),
    .tx_stream_i (tx_stream),
    .uart_tx_i   (uart_tx_o),
    .cfg_i       (cfg)
);

//--- tb_uart_top.sv
/* testbench for the uart top level covering register access, loopback in
   all parity modes, tx back-pressure and bit-banged receiver error frames. */
`timescale 1ns/1ps
`include "uart_macros.svh"

module tb_uart_top;

    import uart_pkg::*;

    localparam int ACK_TIMEOUT = 5000;
    localparam int POLL_LIMIT  = 2000;

    logic                   clk;
    logic                   rstn;
    logic [`UART_ADR_W-1:0] wb_adr;
    logic [31:0]            wb_dat_w;
    logic                   wb_we;
    logic                   wb_stb;
    logic                   wb_cyc;
    logic [31:0]            wb_dat_r;
    logic                   wb_ack;
    logic                   uart_tx;
    logic                   loop_sel;    // 1 feeds tx back into rx.
    logic                   bb_line;
    logic [31:0]            lfsr;
    logic [15:0]            cur_div;
    int                     errors;
    int                     errors_at_start;
    int                     tests_run;
    int                     tests_failed;
    string                  test_name;

    uart_top uut (
        .clk_i     (clk),
        .rstn_i    (rstn),
        .wb_adr_i  (wb_adr),
        .wb_dat_i  (wb_dat_w),
        .wb_we_i   (wb_we),
        .wb_stb_i  (wb_stb),
        .wb_cyc_i  (wb_cyc),
        .wb_dat_o  (wb_dat_r),
        .wb_ack_o  (wb_ack),
        .uart_tx_o (uart_tx),
        .uart_rx_i (loop_sel ? uart_tx : bb_line)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $finish;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("test %s: FAILED, %0d errors", test_name, errors - errors_at_start);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    // right-shifting galois lfsr with taps for x^32+x^22+x^2+x+1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_byte(output logic [7:0] b);
        for (int i = 0; i < `UART_DATA_W; i++) begin
            b[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // one classic cycle with stb dropped after the edge that samples ack.
    task automatic bus_access(input logic we, input logic [`UART_ADR_W-1:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        wb_adr   = adr;
        wb_dat_w = wdata;
        wb_we    = we;
        wb_stb   = 1'b1;
        wb_cyc   = 1'b1;
        waited   = 0;
        rdata    = '0;
        while (!wb_ack && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!wb_ack) begin
            abort_run("bus access timed out waiting for ack");
        end else begin
            rdata = wb_dat_r;
            @(posedge clk);
            #1;
            wb_stb = 1'b0;
            wb_cyc = 1'b0;
            wb_we  = 1'b0;
        end
    endtask

    task automatic wb_write(input logic [`UART_ADR_W-1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [`UART_ADR_W-1:0] adr, output logic [31:0] data);
        bus_access(1'b0, adr, 32'h0, data);
    endtask

    task automatic wait_status(input int bit_idx, input string what, output logic [31:0] st);
        int polls;
        polls = 0;
        wb_read(REG_STATUS, st);
        while (!st[bit_idx] && polls < POLL_LIMIT) begin
            wb_read(REG_STATUS, st);
            polls++;
        end
        if (!st[bit_idx]) abort_run({"timed out waiting for ", what});
    endtask

    task automatic set_ctrl(input logic [15:0] div, input logic odd, input logic even);
        logic [31:0] st;
        wait_status(0, "tx ready", st); // cfg only changes while idle.
        wb_write(REG_CTRL, {14'h0, even, odd, div});
        cur_div = div;
    endtask

    task automatic expect_rx(input logic [7:0] b, input logic [31:0] flags);
        logic [31:0] st;
        logic [31:0] rd;
        wait_status(1, "rx valid", st);
        check_value("status", flags, st & 32'h1e);
        wb_read(REG_RXDATA, rd);
        check_value("rxdata", {24'h0, b}, rd);
        wb_read(REG_STATUS, st);
        check_value("cleared", 32'h0, st & 32'h1e);
    endtask

    task automatic loopback_bytes(input int count);
        logic [7:0] b;
        for (int i = 0; i < count; i++) begin
            random_byte(b);
            wb_write(REG_TXDATA, {24'h0, b});
            expect_rx(b, 32'h2);
        end
    endtask

    task automatic drive_bit(input logic b);
        bb_line = b;
        repeat (cur_div) @(posedge clk);
        #1;
    endtask

    task automatic bitbang_frame(input logic [7:0] d, input logic par_bit, input logic stop_bit);
        drive_bit(1'b0);
        for (int i = 0; i < `UART_DATA_W; i++) begin
            drive_bit(d[i]);
        end
        drive_bit(par_bit);
        drive_bit(stop_bit);
        drive_bit(1'b1);    // idle gap.
    endtask

    initial begin
        logic [31:0] rd;
        logic [7:0]  b0;
        logic [7:0]  b1;
        rstn            = 1'b0;
        wb_adr          = '0;
        wb_dat_w        = '0;
        wb_we           = 1'b0;
        wb_stb          = 1'b0;
        wb_cyc          = 1'b0;
        loop_sel        = 1'b1;
        bb_line         = 1'b1;
        lfsr            = 32'haf41efa4;
        cur_div         = 16'd16;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;

        begin_test("reset");
        wb_read(REG_STATUS, rd);
        check_value("status", 32'h1, rd);
        check_value("tx line", 32'h1, {31'h0, uart_tx});
        end_test();

        begin_test("ctrl_readback");
        wb_write(REG_CTRL, 32'h0003_5a3c);
        wb_read(REG_CTRL, rd);
        check_value("ctrl", 32'h0003_5a3c, rd);
        set_ctrl(16'd16, 1'b0, 1'b0);
        end_test();

        begin_test("loopback_none");
        loopback_bytes(3);
        end_test();
        begin_test("loopback_odd");
        set_ctrl(16'd16, 1'b1, 1'b0);
        loopback_bytes(3);
        end_test();
        begin_test("loopback_even");
        set_ctrl(16'd16, 1'b0, 1'b1);
        loopback_bytes(3);
        end_test();

        // second write is held until the first frame is done, so b0 is already in.
        begin_test("tx_backpressure");
        set_ctrl(16'd16, 1'b0, 1'b0);
        random_byte(b0);
        random_byte(b1);
        wb_write(REG_TXDATA, {24'h0, b0});
        wb_write(REG_TXDATA, {24'h0, b1});
        wb_read(REG_STATUS, rd);
        check_value("first frame done", 32'h2, rd & 32'h1e);
        expect_rx(b0, 32'h2);
        expect_rx(b1, 32'h2);
        end_test();

        begin_test("rx_errors");
        set_ctrl(16'd16, 1'b0, 1'b1);
        loop_sel = 1'b0;
        random_byte(b0);
        random_byte(b1);
        bitbang_frame(b0, ~(^b0), 1'b1);
        expect_rx(b0, 32'h6);
        bitbang_frame(b1, ^b1, 1'b0);
        expect_rx(b1, 32'ha);
        bitbang_frame(b0, ^b0, 1'b1);
        bitbang_frame(b1, ^b1, 1'b1);
        expect_rx(b1, 32'h12);
        loop_sel = 1'b1;
        end_test();

        begin_test("bit_period");
        set_ctrl(16'd12, 1'b0, 1'b0);
        loopback_bytes(2);
        set_ctrl(16'd20, 1'b1, 1'b0);
        loopback_bytes(2);
        check_value("assertion failures", 32'h0, uut.u_sva.fail_cnt);
        end_test();

        $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, uut.u_sva.fail_cnt);
        if (errors == 0 && uut.u_sva.fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
uart_pkg.sv
uart_wb_decode.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
uart_sva.sv
tb_uart_top.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_uart_top
RTL_TOP   ?= uart_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
RTL_SRCS  ?= uart_pkg.sv uart_wb_decode.sv uart_tx.sv uart_rx.sv uart_top.sv
PASS_MSG  ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) +incdir+. --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TB_TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
